// File: verilog.f
mipsPkg.sv
registerFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
pipelineCore.sv
tbCore.sv

// File: tbCore.sv
`timescale 1ns/1ps

module tbCore;
  import mipsPkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int PROG_INSTRS = 12;
  // Instruction k sits at slot 4k with three nops behind it
  localparam int SLOT_STRIDE = 4;
  localparam int WATCHDOG_NS = (IMEM_DEPTH + 10) * CLK_PERIOD * 2;
  // Negedges from rst release up to the first wbValid
  localparam int FIRST_WB_CYCLE = 5;
  localparam logic [31:0] SEED = 32'h01ac_072b;
  localparam word_t NOP = 32'h0000_0000;

  logic     Clk = 1'b0;
  logic     rst;
  logic     imemWrite;
  logic [5:0] imemAddr;
  word_t    imemData;
  logic     wbValid;
  regAddr_t wbReg;
  word_t    wbData;
  logic     storeValid;
  word_t    storeAddr;
  word_t    storeData;

  logic [31:0] lfsr;
  logic [15:0] primeAddr;
  word_t       prog [IMEM_DEPTH];

  // Expected events from the ISA model in order with their test number
  regAddr_t expWbReg [$];
  word_t    expWbData [$];
  int       expWbTag [$];
  word_t    expStAddr [$];
  word_t    expStData [$];
  int       expStTag [$];
  int       nWb;
  int       nSt;

  int    wbIdx;
  int    stIdx;
  int    cycle;
  logic  firstSeen;
  int    testChecks [1:6];
  int    testErrors [1:6];
  string testNames [1:6];

  pipelineCore u_dut (
    .Clk       (Clk),
    .rst       (rst),
    .imemWrite (imemWrite),
    .imemAddr  (imemAddr),
    .imemData  (imemData),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .wbData    (wbData),
    .storeValid(storeValid),
    .storeAddr (storeAddr),
    .storeData (storeData)
  );

  always #(CLK_PERIOD / 2) Clk = ~Clk;

  //////////////////////////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic int unsigned randBits(input int n);
    int unsigned v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  function automatic logic [5:0] functFor(input int sel);
    case (sel)
      0: return FN_ADD;
      1: return FN_SUB;
      2: return FN_AND;
      3: return FN_OR;
      default: return FN_SLT;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected, input int testNo);
    testChecks[testNo]++;
    if (actual !== expected) begin
      testErrors[testNo]++;
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program generator
  //////////////////////////////////////////////////////////////////////

  task automatic buildProgram;
    int k;
    int sel;
    int tgt;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    logic [15:0] imm;
    for (k = 0; k < IMEM_DEPTH; k++) begin
      prog[k] = NOP;
    end
    // Prime r1..r4 with negative immediates possible
    for (k = 0; k < 4; k++) begin
      imm = randBits(16);
      prog[SLOT_STRIDE * k] = {OP_ADDI, 5'd0, 5'(k + 1), imm};
    end
    // Every lw reads this word so no load sees an unwritten location
    primeAddr = 4 * randBits(3);
    rt = 1 + randBits(2);
    prog[SLOT_STRIDE * 4] = {OP_SW, 5'd0, rt, primeAddr};
    for (k = 5; k < PROG_INSTRS; k++) begin
      sel = randBits(3);
      rs = randBits(3) % 5;
      rt = randBits(3) % 5;
      rd = randBits(3) % 5;
      imm = randBits(16);
      // Last slot keeps room for a forward target
      if ((sel == 7) && (k > PROG_INSTRS - 2)) begin
        sel = 0;
      end
      case (sel)
        5: prog[SLOT_STRIDE * k] = {OP_ADDI, rs, rd, imm};
        6: begin
          if (randBits(1) == 1) begin
            prog[SLOT_STRIDE * k] = {OP_SW, 5'd0, rt, 16'(4 * randBits(3))};
          end else begin
            prog[SLOT_STRIDE * k] = {OP_LW, 5'd0, rd, primeAddr};
          end
        end
        7: begin
          tgt = k + 1 + (randBits(4) % (PROG_INSTRS - 1 - k));
          if (randBits(1) == 1) begin
            // Same register twice gives an always-taken beq
            if (randBits(1) == 1) begin
              rt = rs;
            end
            prog[SLOT_STRIDE * k] =
                {OP_BEQ, rs, rt, 16'(SLOT_STRIDE * (tgt - k) - 1)};
          end else begin
            prog[SLOT_STRIDE * k] = {OP_J, 26'(SLOT_STRIDE * tgt)};
          end
        end
        default: prog[SLOT_STRIDE * k] = {OP_RTYPE, rs, rt, rd, 5'd0, functFor(sel)};
      endcase
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // ISA model
  //////////////////////////////////////////////////////////////////////

  task automatic runModel;
    word_t    mReg [32];
    word_t    mMem [DMEM_DEPTH];
    word_t    pc;
    word_t    nextPc;
    word_t    tgt;
    word_t    ins;
    word_t    a;
    word_t    b;
    word_t    imm;
    word_t    addr;
    word_t    wrVal;
    regAddr_t wrReg;
    logic     wrEn;
    logic     afterCtl;
    int       pend;
    int       kind;
    int       i;
    for (i = 0; i < 32; i++) begin
      mReg[i] = '0;
    end
    for (i = 0; i < DMEM_DEPTH; i++) begin
      mMem[i] = '0;
    end
    pc = '0;
    tgt = '0;
    pend = 0;
    afterCtl = 1'b0;
    // Run until the tail of nops with no redirect pending
    while ((pc < SLOT_STRIDE * PROG_INSTRS * 4) || (pend != 0)) begin
      ins = prog[pc[7:2]];
      nextPc = pc + 32'd4;
      a = mReg[ins[25:21]];
      b = mReg[ins[20:16]];
      imm = {{16{ins[15]}}, ins[15:0]};
      addr = a + imm;
      wrEn = 1'b0;
      wrReg = ins[20:16];
      wrVal = '0;
      kind = 3;
      case (ins[31:26])
        OP_RTYPE: begin
          wrEn = 1'b1;
          wrReg = ins[15:11];
          kind = 2;
          case (ins[5:0])
            FN_ADD:  wrVal = a + b;
            FN_SUB:  wrVal = a - b;
            FN_AND:  wrVal = a & b;
            FN_OR:   wrVal = a | b;
            FN_SLT:  wrVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: wrEn = 1'b0;
          endcase
        end
        OP_ADDI: begin
          wrEn = 1'b1;
          wrVal = addr;
        end
        OP_LW: begin
          wrEn = 1'b1;
          wrVal = mMem[addr[7:2]];
          kind = 4;
        end
        OP_SW: begin
          mMem[addr[7:2]] = b;
          expStAddr.push_back(addr);
          expStData.push_back(b);
          expStTag.push_back(afterCtl ? 5 : 4);
        end
        OP_BEQ: begin
          afterCtl = 1'b1;
          if (a == b) begin
            pend = 4;
            tgt = nextPc + {imm[29:0], 2'b00};
          end
        end
        OP_J: begin
          afterCtl = 1'b1;
          pend = 4;
          tgt = {nextPc[31:28], ins[25:0], 2'b00};
        end
        default: ;
      endcase
      if (wrEn && (wrReg != '0)) begin
        mReg[wrReg] = wrVal;
        expWbReg.push_back(wrReg);
        expWbData.push_back(wrVal);
        expWbTag.push_back(afterCtl ? 5 : kind);
      end
      // Branch plus three slots and then the target
      pc = (pend == 1) ? tgt : nextPc;
      if (pend > 0) begin
        pend--;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge Clk) begin
    if (rst) begin
      check("wbValid", wbValid, 1'b0, 1);
      check("storeValid", storeValid, 1'b0, 1);
    end else begin
      cycle++;
      if (wbValid === 1'b1) begin
        if (!firstSeen) begin
          check("firstWbCycle", cycle, FIRST_WB_CYCLE, 1);
          firstSeen = 1'b1;
        end
        check("wbRegNonZero", wbReg != '0, 1'b1, 3);
        if (wbIdx < nWb) begin
          check("wbReg", wbReg, expWbReg[wbIdx], expWbTag[wbIdx]);
          check("wbData", wbData, expWbData[wbIdx], expWbTag[wbIdx]);
        end else begin
          testErrors[6]++;
          $display("Unexpected register write to r%0d at %0t beyond the model's list",
                   wbReg, $time);
        end
        wbIdx++;
      end
      if (storeValid === 1'b1) begin
        if (stIdx < nSt) begin
          check("storeAddr", storeAddr, expStAddr[stIdx], expStTag[stIdx]);
          check("storeData", storeData, expStData[stIdx], expStTag[stIdx]);
        end else begin
          testErrors[6]++;
          $display("Unexpected store at %0t beyond the model's list", $time);
        end
        stIdx++;
      end
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0d ns with %0d of %0d writes and %0d of %0d stores seen",
             WATCHDOG_NS, wbIdx, nWb, stIdx, nSt);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int k;
    int passCnt;
    int failCnt;
    rst = 1'b1;
    imemWrite = 1'b0;
    imemAddr = '0;
    imemData = NOP;
    lfsr = SEED;
    wbIdx = 0;
    stIdx = 0;
    cycle = 0;
    firstSeen = 1'b0;
    passCnt = 0;
    failCnt = 0;
    for (k = 1; k <= 6; k++) begin
      testChecks[k] = 0;
      testErrors[k] = 0;
    end
    testNames[1] = "reset quiet";
    testNames[2] = "R-type ALU";
    testNames[3] = "addi and r0";
    testNames[4] = "store and load";
    testNames[5] = "branch and jump path";
    testNames[6] = "completion";
    buildProgram();
    runModel();
    nWb = expWbData.size();
    nSt = expStData.size();

    // Load under reset at one word per cycle
    #1;
    for (k = 0; k < IMEM_DEPTH; k++) begin
      imemWrite = 1'b1;
      imemAddr = k;
      imemData = prog[k];
      @(posedge Clk);
      #1;
    end
    imemWrite = 1'b0;
    // Three more reset cycles after the load
    repeat (3) @(posedge Clk);
    #1;
    rst = 1'b0;

    wait ((wbIdx >= nWb) && (stIdx >= nSt));
    // Short drain that ends well before the PC wraps
    repeat (6) @(posedge Clk);
    check("wbCount", wbIdx, nWb, 6);
    check("storeCount", stIdx, nSt, 6);

    for (k = 1; k <= 6; k++) begin
      $display("Test %0d %s: %0d checks, %0d errors, %s", k, testNames[k],
               testChecks[k], testErrors[k], (testErrors[k] == 0) ? "ok" : "failing");
      if (testErrors[k] == 0) begin
        passCnt++;
      end else begin
        failCnt++;
      end
    end
    $display("Summary: %0d tests ok, %0d tests failing", passCnt, failCnt);
    if (failCnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: pipelineCore.sv
`timescale 1ns/1ps

module pipelineCore (
  input  logic              Clk,
  input  logic              rst,
  input  logic              imemWrite,
  input  logic [5:0]        imemAddr,
  input  mipsPkg::word_t    imemData,
  output logic              wbValid,
  output mipsPkg::regAddr_t wbReg,
  output mipsPkg::word_t    wbData,
  output logic              storeValid,
  output mipsPkg::word_t    storeAddr,
  output mipsPkg::word_t    storeData
);
  import mipsPkg::*;

  // Redirect back to fetch
  logic  redirect;
  word_t redirectPc;

  // Fetch/decode
  word_t instrDecode, pcPlus4Decode;

  // Decode/execute
  word_t       pcPlus4Execute, readData1Execute, readData2Execute, immExecute;
  logic [25:0] jumpIndexExecute;
  regAddr_t    destRegExecute;
  aluOp_t      aluOpExecute;
  logic        aluSrcExecute, regWriteExecute, memReadExecute;
  logic        memWriteExecute, branchExecute, jumpExecute;

  // Execute/memory
  word_t    aluResultMemory, storeDataMemory, targetMemory;
  logic     zeroMemory;
  regAddr_t destRegMemory;
  logic     regWriteMemory, memReadMemory, memWriteMemory, branchMemory, jumpMemory;

  fetchStage fetch (.*);

  // Writeback ports feed the register file and the top outputs
  decodeStage decode (.*);

  executeStage execute (.*);

  memoryStage memory (.*);

endmodule

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
  input  logic              Clk,
  input  logic              rst,
  input  mipsPkg::word_t    aluResultMemory,
  input  mipsPkg::word_t    storeDataMemory,
  input  mipsPkg::word_t    targetMemory,
  input  logic              zeroMemory,
  input  mipsPkg::regAddr_t destRegMemory,
  input  logic              regWriteMemory,
  input  logic              memReadMemory,
  input  logic              memWriteMemory,
  input  logic              branchMemory,
  input  logic              jumpMemory,
  output logic              redirect,
  output mipsPkg::word_t    redirectPc,
  output logic              storeValid,
  output mipsPkg::word_t    storeAddr,
  output mipsPkg::word_t    storeData,
  output logic              wbValid,
  output mipsPkg::regAddr_t wbReg,
  output mipsPkg::word_t    wbData
);
  import mipsPkg::*;

  word_t dmem [DMEM_DEPTH];
  word_t loadData;

  // Word index, wraps modulo depth
  logic [$clog2(DMEM_DEPTH)-1:0] dmemIdx;
  assign dmemIdx = aluResultMemory[$clog2(DMEM_DEPTH)+1:2];

  // Asynchronous read for lw
  assign loadData = dmem[dmemIdx];

  // Store, written at the end of the reporting cycle
  always_ff @(posedge Clk) begin
    if (memWriteMemory) begin
      dmem[dmemIdx] <= storeDataMemory;
    end
  end

  // Store report
  assign storeValid = memWriteMemory;
  assign storeAddr  = aluResultMemory;
  assign storeData  = storeDataMemory;

  // Taken beq or any j
  // PC follows at the next edge
  assign redirect   = (branchMemory & zeroMemory) | jumpMemory;
  assign redirectPc = targetMemory;

  //////////////////////////////////////////////////////////////////////
  // Memory/writeback register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (rst) begin
      wbValid <= 1'b0;
    end else begin
      wbValid <= regWriteMemory;
    end
  end

  // Loaded word for lw, ALU result otherwise
  always_ff @(posedge Clk) begin
    wbReg  <= destRegMemory;
    wbData <= memReadMemory ? loadData : aluResultMemory;
  end

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic              Clk,
  input  logic              rst,
  input  mipsPkg::word_t    pcPlus4Execute,
  input  mipsPkg::word_t    readData1Execute,
  input  mipsPkg::word_t    readData2Execute,
  input  mipsPkg::word_t    immExecute,
  input  logic [25:0]       jumpIndexExecute,
  input  mipsPkg::regAddr_t destRegExecute,
  input  mipsPkg::aluOp_t   aluOpExecute,
  input  logic              aluSrcExecute,
  input  logic              regWriteExecute,
  input  logic              memReadExecute,
  input  logic              memWriteExecute,
  input  logic              branchExecute,
  input  logic              jumpExecute,
  output mipsPkg::word_t    aluResultMemory,
  output mipsPkg::word_t    storeDataMemory,
  output mipsPkg::word_t    targetMemory,
  output logic              zeroMemory,
  output mipsPkg::regAddr_t destRegMemory,
  output logic              regWriteMemory,
  output logic              memReadMemory,
  output logic              memWriteMemory,
  output logic              branchMemory,
  output logic              jumpMemory
);
  import mipsPkg::*;

  word_t aluB;
  word_t aluResult;
  word_t target;

  // Second operand is rt or the immediate
  assign aluB = aluSrcExecute ? immExecute : readData2Execute;

  // ALU
  always_comb begin
    case (aluOpExecute)
      ALU_ADD: aluResult = readData1Execute + aluB;
      ALU_SUB: aluResult = readData1Execute - aluB;
      ALU_AND: aluResult = readData1Execute & aluB;
      ALU_OR:  aluResult = readData1Execute | aluB;
      // Signed compare
      ALU_SLT: aluResult = {31'd0, $signed(readData1Execute) < $signed(aluB)};
      default: aluResult = '0;
    endcase
  end

  // Jump keeps the upper PC nibble, beq is PC+4 plus word offset
  assign target = jumpExecute ? {pcPlus4Execute[31:28], jumpIndexExecute, 2'b00}
                              : pcPlus4Execute + {immExecute[29:0], 2'b00};

  //////////////////////////////////////////////////////////////////////
  // Execute/memory register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (rst) begin
      {regWriteMemory, memReadMemory, memWriteMemory} <= '0;
      {branchMemory, jumpMemory} <= '0;
    end else begin
      {regWriteMemory, memReadMemory, memWriteMemory} <=
          {regWriteExecute, memReadExecute, memWriteExecute};
      {branchMemory, jumpMemory} <= {branchExecute, jumpExecute};
    end
  end

  always_ff @(posedge Clk) begin
    aluResultMemory <= aluResult;
    storeDataMemory <= readData2Execute;
    targetMemory    <= target;
    zeroMemory      <= (aluResult == '0);
    destRegMemory   <= destRegExecute;
  end

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic              Clk,
  input  logic              rst,
  input  mipsPkg::word_t    instrDecode,
  input  mipsPkg::word_t    pcPlus4Decode,
  input  logic              wbValid,
  input  mipsPkg::regAddr_t wbReg,
  input  mipsPkg::word_t    wbData,
  output mipsPkg::word_t    pcPlus4Execute,
  output mipsPkg::word_t    readData1Execute,
  output mipsPkg::word_t    readData2Execute,
  output mipsPkg::word_t    immExecute,
  output logic [25:0]       jumpIndexExecute,
  output mipsPkg::regAddr_t destRegExecute,
  output mipsPkg::aluOp_t   aluOpExecute,
  output logic              aluSrcExecute,
  output logic              regWriteExecute,
  output logic              memReadExecute,
  output logic              memWriteExecute,
  output logic              branchExecute,
  output logic              jumpExecute
);
  import mipsPkg::*;

  // Instruction fields
  logic [5:0] opcode;
  logic [5:0] funct;
  regAddr_t   rs;
  regAddr_t   rt;
  regAddr_t   rd;
  assign opcode = instrDecode[31:26];
  assign rs     = instrDecode[25:21];
  assign rt     = instrDecode[20:16];
  assign rd     = instrDecode[15:11];
  assign funct  = instrDecode[5:0];

  word_t    immExt;
  word_t    readData1;
  word_t    readData2;
  regAddr_t destReg;
  aluOp_t   aluOp;
  logic     aluSrc, regWrite, memRead, memWrite, branch, jump;

  // Sign extension of the 16-bit immediate
  assign immExt = {{16{instrDecode[15]}}, instrDecode[15:0]};

  // Reads in decode, writes from the writeback register
  registerFile regFile (
    .Clk        (Clk),
    .readReg1   (rs),
    .readReg2   (rt),
    .readData1  (readData1),
    .readData2  (readData2),
    .writeEnable(wbValid),
    .writeReg   (wbReg),
    .writeData  (wbData)
  );

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Nop unless an encoding below matches
    {aluSrc, regWrite, memRead, memWrite, branch, jump} = '0;
    aluOp   = ALU_ADD;
    destReg = rt;
    case (opcode)
      OP_RTYPE: begin
        destReg  = rd;
        regWrite = 1'b1;
        case (funct)
          FN_ADD:  aluOp = ALU_ADD;
          FN_SUB:  aluOp = ALU_SUB;
          FN_AND:  aluOp = ALU_AND;
          FN_OR:   aluOp = ALU_OR;
          FN_SLT:  aluOp = ALU_SLT;
          // Unknown funct also covers sll 0,0,0
          default: regWrite = 1'b0;
        endcase
      end
      OP_ADDI: {aluSrc, regWrite} = 2'b11;
      OP_LW:   {aluSrc, regWrite, memRead} = 3'b111;
      OP_SW:   {aluSrc, memWrite} = 2'b11;
      // Zero flag from rs - rt
      OP_BEQ: begin
        branch = 1'b1;
        aluOp  = ALU_SUB;
      end
      OP_J:    jump = 1'b1;
      default: ;
    endcase
    // Register 0 never written
    if (destReg == '0) begin
      regWrite = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decode/execute register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (rst) begin
      {aluSrcExecute, regWriteExecute, memReadExecute} <= '0;
      {memWriteExecute, branchExecute, jumpExecute} <= '0;
    end else begin
      {aluSrcExecute, regWriteExecute, memReadExecute} <= {aluSrc, regWrite, memRead};
      {memWriteExecute, branchExecute, jumpExecute} <= {memWrite, branch, jump};
    end
  end

  always_ff @(posedge Clk) begin
    pcPlus4Execute   <= pcPlus4Decode;
    readData1Execute <= readData1;
    readData2Execute <= readData2;
    immExecute       <= immExt;
    jumpIndexExecute <= instrDecode[25:0];
    destRegExecute   <= destReg;
    aluOpExecute     <= aluOp;
  end

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
  input  logic           Clk,
  input  logic           rst,
  input  logic           imemWrite,
  input  logic [5:0]     imemAddr,
  input  mipsPkg::word_t imemData,
  input  logic           redirect,
  input  mipsPkg::word_t redirectPc,
  output mipsPkg::word_t instrDecode,
  output mipsPkg::word_t pcPlus4Decode
);
  import mipsPkg::*;

  // Program counter and sequential successor
  word_t pc;
  word_t pcPlus4;
  word_t fetchedInstr;

  // Instruction store, filled through the load port
  word_t imem [IMEM_DEPTH];

  assign pcPlus4 = pc + 32'd4;

  // Word index of the PC, wraps modulo depth
  assign fetchedInstr = imem[pc[$clog2(IMEM_DEPTH)+1:2]];

  // Load port
  // Write lands on the edge where the strobe is high
  always_ff @(posedge Clk) begin
    if (imemWrite) begin
      imem[imemAddr] <= imemData;
    end
  end

  // Next PC
  // Redirect from the memory stage wins over PC+4
  always_ff @(posedge Clk) begin
    if (rst) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirectPc;
    end else begin
      pc <= pcPlus4;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fetch/decode register
  //////////////////////////////////////////////////////////////////////

  // All-zero word decodes as a nop
  always_ff @(posedge Clk) begin
    if (rst) begin
      instrDecode <= '0;
    end else begin
      instrDecode <= fetchedInstr;
    end
  end

  always_ff @(posedge Clk) begin
    pcPlus4Decode <= pcPlus4;
  end

endmodule

// File: registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic              Clk,
  input  mipsPkg::regAddr_t readReg1,
  input  mipsPkg::regAddr_t readReg2,
  output mipsPkg::word_t    readData1,
  output mipsPkg::word_t    readData2,
  input  logic              writeEnable,
  input  mipsPkg::regAddr_t writeReg,
  input  mipsPkg::word_t    writeData
);
  import mipsPkg::*;

  word_t regs [32];

  // One read port
  // Register 0 is zero, a same-cycle write passes straight through
  function automatic word_t readPort(input regAddr_t addr, input word_t stored,
                                     input logic wrEn, input regAddr_t wrReg,
                                     input word_t wrData);
    if (addr == '0) begin
      return '0;
    end else if (wrEn && (wrReg == addr)) begin
      return wrData;
    end
    return stored;
  endfunction

  always_ff @(posedge Clk) begin
    if (writeEnable && (writeReg != '0)) begin
      regs[writeReg] <= writeData;
    end
  end

  always_comb begin
    readData1 = readPort(readReg1, regs[readReg1], writeEnable, writeReg, writeData);
    readData2 = readPort(readReg2, regs[readReg2], writeEnable, writeReg, writeData);
  end

endmodule

// File: mipsPkg.sv
package mipsPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////////////////////////

  // Data word, instruction word or byte address
  typedef logic [31:0] word_t;

  // Register number, rs/rt/rd field
  typedef logic [4:0] regAddr_t;

  // ALU operation select
  typedef logic [2:0] aluOp_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Primary opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // R-type funct field, instr[5:0]
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  // ALU operations
  localparam aluOp_t ALU_ADD = 3'd0;
  localparam aluOp_t ALU_SUB = 3'd1;
  localparam aluOp_t ALU_AND = 3'd2;
  localparam aluOp_t ALU_OR  = 3'd3;
  localparam aluOp_t ALU_SLT = 3'd4;

  //////////////////////////////////////////////////////////////////////
  // Memory sizes in words
  //////////////////////////////////////////////////////////////////////

  // Addresses wrap on the word index bits
  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;

endpackage
